//--- run.sh
#!/bin/sh
# build and run tb_mips_core with Verilator, result taken from sim.log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_mips_core \
	-f src.f && ./obj_dir/Vtb_mips_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- src.f
verilog/mips_pkg.sv
verilog/core_if.sv
verilog/instruction_memory.sv
verilog/fetch_unit.sv
verilog/instruction_decoder.sv
verilog/register_file.sv
verilog/alu.sv
verilog/data_memory.sv
verilog/mips_core.sv
verification/mips_ref_model.sv
verification/tb_mips_core.sv

//--- verification/mips_ref_model.sv
// ############################
// forward-only beq, program always ends
// words past the program are nop
// ############################
module mips_ref_model;
	timeunit 1ns;
	timeprecision 1ps;
	import mips_pkg::*;

	localparam int PROG_LEN   = 48;
	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;

	typedef enum int
	{
		K_ADD, K_SUB, K_AND, K_OR, K_SLT, K_SLL, K_SRL, K_ADDI, K_LW, K_SW, K_BEQ, K_NOP
	} kind_e;

	integer      seed; // $random state
	kind_e       kind [IMEM_WORDS]; // what each word does
	reg_idx_t    f_rs [IMEM_WORDS];
	reg_idx_t    f_rt [IMEM_WORDS];
	reg_idx_t    f_rd [IMEM_WORDS];
	logic [4:0]  f_shamt [IMEM_WORDS];
	logic [15:0] f_imm [IMEM_WORDS];
	word_t       imem_word [IMEM_WORDS]; // encoded image for the load port
	word_t       regs [32];
	word_t       dmem [DMEM_WORDS];
	logic [7:0]  pc; // byte address, wraps at 256

	function automatic int pick(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic word_t encode_r(funct_e fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
		logic [4:0] sh);
		r_fields_t f;
		f.opcode = OP_RTYPE;
		f.rs     = rs;
		f.rt     = rt;
		f.rd     = rd;
		f.shamt  = sh;
		f.funct  = fn;
		return word_t'(f);
	endfunction

	function automatic word_t encode_i(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
		i_fields_t f;
		f.opcode = op;
		f.rs     = rs;
		f.rt     = rt;
		f.imm    = imm;
		return word_t'(f);
	endfunction

	function automatic funct_e funct_of(kind_e k);
		case (k)
			K_SUB:   return FN_SUB;
			K_AND:   return FN_AND;
			K_OR:    return FN_OR;
			K_SLT:   return FN_SLT;
			K_SLL:   return FN_SLL;
			K_SRL:   return FN_SRL;
			default: return FN_ADD;
		endcase
	endfunction

	task automatic build_program();
		seed = 32'h467f;
		for (int k = 0; k < IMEM_WORDS; k++)
		begin
			kind[k]    = (k >= PROG_LEN) ? K_NOP : (k < 8) ? K_ADDI : kind_e'(pick(11));
			f_rs[k]    = reg_idx_t'(pick(8)); // r0..r7 so results get reused
			f_rt[k]    = (k < 8) ? reg_idx_t'(7 - k) : reg_idx_t'(pick(8)); // seed r7..r0 first
			f_rd[k]    = reg_idx_t'(pick(8));
			f_shamt[k] = 5'(pick(32));
			f_imm[k]   = 16'($random(seed));
			case (kind[k])
				K_NOP:
				begin
					f_rs[k]      = '0;
					f_rt[k]      = '0;
					f_rd[k]      = '0;
					imem_word[k] = '0; // all-zero word
				end
				K_SLL, K_SRL: imem_word[k] = encode_r(funct_of(kind[k]), f_rs[k], f_rt[k],
					f_rd[k], f_shamt[k]);
				K_ADDI: imem_word[k] = encode_i(OP_ADDI, f_rs[k], f_rt[k], f_imm[k]);
				K_LW, K_SW:
				begin
					f_rs[k]      = (pick(4) == 0) ? f_rs[k] : '0; // mostly absolute address
					f_imm[k]     = 16'((pick(16) << 2) | (pick(4) << 8)); // bits 8,9 ignored
					imem_word[k] = encode_i((kind[k] == K_LW) ? OP_LW : OP_SW, f_rs[k],
						f_rt[k], f_imm[k]);
				end
				K_BEQ:
				begin
					if (pick(2) == 0)
						f_rt[k] = f_rs[k]; // equal operands, taken
					f_imm[k]     = 16'(pick(4)); // forward 0..3 words
					imem_word[k] = encode_i(OP_BEQ, f_rs[k], f_rt[k], f_imm[k]);
				end
				default:
				begin
					f_shamt[k]   = '0;
					imem_word[k] = encode_r(funct_of(kind[k]), f_rs[k], f_rt[k], f_rd[k], '0);
				end
			endcase
		end
	endtask

	task automatic reset_state();
		for (int k = 0; k < 32; k++)
			regs[k] = '0;
		for (int k = 0; k < DMEM_WORDS; k++)
			dmem[k] = '0;
		pc = '0;
	endtask

	// one architectural instruction, returns what the trace ports should show
	task automatic step(output word_t pc_out, output logic wb_en, output reg_idx_t wb_reg,
		output word_t wb_data, output logic st_en, output word_t st_addr,
		output word_t st_data, output logic wrapped);
		int         idx;
		word_t      a;
		word_t      b;
		word_t      addr;
		word_t      value;
		reg_idx_t   dest;
		logic       writes;
		logic [7:0] next_pc;
		idx     = int'(pc) / 4;
		a       = regs[f_rs[idx]];
		b       = regs[f_rt[idx]];
		addr    = a + {{16{f_imm[idx][15]}}, f_imm[idx]}; // rs + sign-extended imm
		value   = '0;
		dest    = (kind[idx] inside {K_ADDI, K_LW}) ? f_rt[idx] : f_rd[idx];
		writes  = !(kind[idx] inside {K_SW, K_BEQ});
		st_en   = 1'b0;
		st_addr = '0;
		st_data = '0;
		next_pc = pc + 8'd4;
		case (kind[idx])
			K_ADD:  value = a + b;
			K_SUB:  value = a - b;
			K_AND:  value = a & b;
			K_OR:   value = a | b;
			K_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			K_SLL:  value = b << f_shamt[idx];
			K_SRL:  value = b >> f_shamt[idx];
			K_ADDI: value = addr;
			K_LW:   value = dmem[(addr % 256) / 4];
			K_SW:
			begin
				dmem[(addr % 256) / 4] = b;
				st_en   = 1'b1;
				st_addr = addr & 32'h0000_00fc; // only bits 7..2 reach memory
				st_data = b;
			end
			K_BEQ:
			begin
				if (a == b)
					next_pc = pc + 8'd4 + 8'(32'(f_imm[idx]) * 4);
			end
			default: value = '0; // nop
		endcase
		wb_en = writes && (dest != '0); // r0 writes never seen
		if (wb_en)
			regs[dest] = value;
		pc_out  = word_t'(pc);
		wb_reg  = dest;
		wb_data = value;
		wrapped = (next_pc < pc); // ran past the last nop
		pc      = next_pc;
	endtask

endmodule

//--- verification/tb_mips_core.sv
// ############################
// random program, checked per retire
// ends when the pc wraps past the nop tail
// ############################
module tb_mips_core;
	timeunit 1ns;
	timeprecision 1ps;
	import mips_pkg::*;

	localparam int PC_W           = 8;
	localparam int DMEM_AW        = 6;
	localparam int IMEM_WORDS     = 2 ** (PC_W - 2);
	localparam int TIMEOUT_CYCLES = 48 + 16 + 20; // program, nop tail, margin

	logic            clk;
	logic            reset;
	logic            load_en;
	logic [PC_W-3:0] load_addr;
	word_t           load_data;
	logic            retire_valid;
	logic [PC_W-1:0] retire_pc;
	logic            retire_wb_en;
	reg_idx_t        retire_wb_reg;
	word_t           retire_wb_data;
	logic            store_en;
	word_t           store_addr;
	word_t           store_data;

	int       error_count;
	int       check_count;
	int       retire_count;
	int       run_cycles = 0; // cycles out of reset
	word_t    exp_pc;
	logic     exp_wb_en;
	reg_idx_t exp_wb_reg;
	word_t    exp_wb_data;
	logic     exp_st_en;
	word_t    exp_st_addr;
	word_t    exp_st_data;
	logic     wrapped;

	mips_core #(.PC_W (PC_W), .DMEM_AW (DMEM_AW)) i_mips_core
	(
		.clk            (clk),
		.reset          (reset),
		.load_en        (load_en),
		.load_addr      (load_addr),
		.load_data      (load_data),
		.retire_valid   (retire_valid),
		.retire_pc      (retire_pc),
		.retire_wb_en   (retire_wb_en),
		.retire_wb_reg  (retire_wb_reg),
		.retire_wb_data (retire_wb_data),
		.store_en       (store_en),
		.store_addr     (store_addr),
		.store_data     (store_data)
	);

	mips_ref_model i_ref_model ();

	always #50 clk = ~clk; // 100 ns period

	task automatic check_word(string name, word_t expected, word_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("error %s at retire %0d: expected %h, actual %h", name, retire_count,
				expected, actual);
		end
	endtask

	task automatic check_reg(string name, reg_idx_t expected, reg_idx_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("error %s at retire %0d: expected %0d, actual %0d", name, retire_count,
				expected, actual);
		end
	endtask

	task automatic check_bit(string name, logic expected, logic actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("error %s at retire %0d: expected %b, actual %b", name, retire_count,
				expected, actual);
		end
	endtask

	// whole imem incl. the zero tail, core held in reset
	task automatic load_program();
		@(posedge clk);
		load_en   <= 1'b1; // a store parked at pc 0 first
		load_addr <= '0;
		load_data <= i_ref_model.encode_i(OP_SW, 5'd0, 5'd1, 16'h0010);
		@(posedge clk);
		load_en <= 1'b0;
		@(negedge clk);
		check_bit("store_en in reset", 1'b0, store_en);
		for (int k = 0; k < IMEM_WORDS; k++)
		begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_addr <= k[PC_W-3:0];
			load_data <= i_ref_model.imem_word[k];
		end
		@(posedge clk);
		load_en <= 1'b0; // last word lands on this edge
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_bit("retire_valid in reset", 1'b0, retire_valid);
		check_bit("retire_wb_en in reset", 1'b0, retire_wb_en); // pc 0 holds addi r7
		@(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic run_program();
		wrapped = 1'b0;
		while (!wrapped)
		begin
			@(negedge clk); // outputs settled mid-cycle
			retire_count++;
			i_ref_model.step(exp_pc, exp_wb_en, exp_wb_reg, exp_wb_data, exp_st_en,
				exp_st_addr, exp_st_data, wrapped);
			check_bit("retire_valid", 1'b1, retire_valid);
			check_word("retire_pc", exp_pc, word_t'(retire_pc));
			check_bit("retire_wb_en", exp_wb_en, retire_wb_en);
			if (exp_wb_en)
			begin
				check_reg("retire_wb_reg", exp_wb_reg, retire_wb_reg);
				check_word("retire_wb_data", exp_wb_data, retire_wb_data);
			end
			check_bit("store_en", exp_st_en, store_en);
			if (exp_st_en)
			begin
				check_word("store_addr", exp_st_addr, store_addr);
				check_word("store_data", exp_st_data, store_data);
			end
		end
	endtask

	initial
	begin
		clk          = 1'b0;
		reset        = 1'b1;
		load_en      = 1'b0;
		load_addr    = '0;
		load_data    = '0;
		error_count  = 0;
		check_count  = 0;
		retire_count = 0;
		i_ref_model.build_program();
		i_ref_model.reset_state();
		load_program();
		run_program();
		$display("checks %0d, errors %0d, retired %0d", check_count, error_count, retire_count);
		if (error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// the pc must wrap well before this
	always @(posedge clk)
	begin
		if (!reset)
		begin
			run_cycles <= run_cycles + 1;
			if (run_cycles >= TIMEOUT_CYCLES)
			begin
				error_count = error_count + 1;
				$display("timeout: the program never finished within %0d cycles", run_cycles);
				$display("checks %0d, errors %0d, retired %0d", check_count, error_count,
					retire_count);
				$display("Something failed");
				$finish;
			end
		end
	end

endmodule

//--- verilog/alu.sv
// ############################
// shifts act on b by shamt
// slt is signed
// ############################
module alu
(
	input  mips_pkg::word_t    a, // rs
	input  mips_pkg::word_t    b, // rt or imm
	input  logic [4:0]         shamt,
	input  mips_pkg::alu_op_e  op,
	output mips_pkg::word_t    result,
	output logic               zero // for beq
);
	import mips_pkg::*;

	logic a_lt_b; // signed compare

	assign a_lt_b = $signed(a) < $signed(b);

	always_comb
	begin
		case (op)
			ALU_ADD: result = a + b; // also address calc
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_SLT: result = word_t'(a_lt_b);
			ALU_SLL: result = b << shamt;
			ALU_SRL: result = b >> shamt; // logical, zero fill
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- verilog/core_if.sv
// ############################
// reads are combinational
// writes land on the next clk edge
// ############################
interface regfile_if;
	import mips_pkg::*;

	reg_idx_t ra1; // rs port
	reg_idx_t ra2; // rt port
	reg_idx_t wa; // write index, 0 is dropped
	word_t    wd; // write-back data
	logic     we;
	word_t    rd1;
	word_t    rd2;

	modport core (output ra1, ra2, wa, wd, we, input rd1, rd2);
	modport regs (input ra1, ra2, wa, wd, we, output rd1, rd2);
endinterface

interface dmem_if;
	import mips_pkg::*;

	word_t addr; // byte address, memory picks the word bits
	word_t wdata;
	logic  we;
	word_t rdata; // combinational

	modport core (output addr, wdata, we, input rdata);
	modport mem (input addr, wdata, we, output rdata);
endinterface

//--- verilog/data_memory.sv
// ############################
// word access only, no byte enables
// high address bits ignored
// ############################
module data_memory
#(
	parameter int DMEM_AW = 6 // word address width
)
(
	input  logic     clk,
	input  logic     reset,
	dmem_if.mem      dm
);
	import mips_pkg::*;

	localparam int DEPTH = 2 ** DMEM_AW;

	word_t              mem [DEPTH];
	logic [DMEM_AW-1:0] word_idx; // byte addr bits DMEM_AW+1..2

	assign word_idx = dm.addr[DMEM_AW+1:2];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int k = 0; k < DEPTH; k++)
			begin
				mem[k] <= '0; // known start for loads
			end
		end
		else if (dm.we)
		begin
			mem[word_idx] <= dm.wdata;
		end
	end

	assign dm.rdata = mem[word_idx]; // lw sees it same cycle

	// core must keep stores off while the program is loading
	a_no_store_in_reset : assert property (@(posedge clk) reset |-> !dm.we)
		else $error("data_memory: store during reset");

endmodule

//--- verilog/fetch_unit.sv
// ############################
// pc wraps modulo 2^PC_W
// branch_offset counts words
// ############################
module fetch_unit
#(
	parameter int PC_W = 8
)
(
	input  logic                clk,
	input  logic                reset,
	input  logic                load_en,
	input  logic [PC_W-3:0]     load_addr,
	input  mips_pkg::word_t     load_data,
	input  logic                branch_taken,
	input  mips_pkg::word_t     branch_offset, // sign-extended imm
	output logic [PC_W-1:0]     pc,
	output mips_pkg::instr_u    instruction
);
	import mips_pkg::*;

	logic [PC_W-1:0] pc_plus4; // sequential
	logic [PC_W-1:0] branch_target; // pc + 4 + 4*imm
	logic [PC_W-1:0] next_pc;
	word_t           fetched_word; // raw word before the union view

	assign pc_plus4      = pc + PC_W'(4);
	assign branch_target = pc_plus4 + {branch_offset[PC_W-3:0], 2'b00}; // upper bits wrap away
	assign next_pc       = branch_taken ? branch_target : pc_plus4;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0; // held at 0 during program load
		end
		else
		begin
			pc <= next_pc; // one instruction per clock
		end
	end

	instruction_memory
	#(
		.PC_W (PC_W)
	)
	i_instruction_memory
	(
		.clk         (clk),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.pc          (pc),
		.instruction (fetched_word)
	);

	assign instruction = fetched_word;

endmodule

//--- verilog/instruction_decoder.sv
// ############################
// unknown opcode or funct decodes as nop
// ############################
module instruction_decoder
(
	input  mips_pkg::instr_u   instruction,
	regfile_if.core            rf,
	output mips_pkg::alu_op_e  alu_op,
	output logic               alu_src_imm, // b from imm instead of rt
	output logic               use_shamt,
	output logic               mem_read,
	output logic               mem_write,
	output logic               is_branch,
	output mips_pkg::word_t    imm,
	output logic [4:0]         shamt
);
	import mips_pkg::*;

	logic legal_op; // opcode is one we run

	assign imm   = word_t'($signed(instruction.i.imm)); // sign extend
	assign shamt = instruction.r.shamt;

	always_comb
	begin
		rf.ra1      = instruction.r.rs; // same bits in both views
		rf.ra2      = instruction.r.rt;
		rf.wa       = '0;
		rf.we       = 1'b0;
		alu_op      = ALU_ADD;
		alu_src_imm = 1'b0;
		use_shamt   = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		is_branch   = 1'b0;
		legal_op    = 1'b1;

		case (instruction.r.opcode)
			OP_RTYPE:
			begin
				rf.wa = instruction.r.rd;
				rf.we = 1'b1;
				case (instruction.r.funct)
					FN_ADD: alu_op = ALU_ADD;
					FN_SUB: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR:  alu_op = ALU_OR;
					FN_SLT: alu_op = ALU_SLT;
					FN_SLL:
					begin
						alu_op    = ALU_SLL; // rt << shamt
						use_shamt = 1'b1;
					end
					FN_SRL:
					begin
						alu_op    = ALU_SRL;
						use_shamt = 1'b1;
					end
					default: rf.we = 1'b0; // unknown funct, no write
				endcase
			end
			OP_ADDI:
			begin
				rf.wa       = instruction.i.rt;
				rf.we       = 1'b1;
				alu_src_imm = 1'b1;
			end
			OP_LW:
			begin
				rf.wa       = instruction.i.rt; // load target
				rf.we       = 1'b1;
				alu_src_imm = 1'b1; // rs + imm
				mem_read    = 1'b1;
			end
			OP_SW:
			begin
				alu_src_imm = 1'b1;
				mem_write   = 1'b1; // data from rt via ra2
			end
			OP_BEQ:
			begin
				alu_op    = ALU_SUB; // zero flag means equal
				is_branch = 1'b1;
			end
			default: legal_op = 1'b0; // falls through as nop
		endcase

		// memory never loaded still reads unknown
		if (!$isunknown(instruction))
		begin
			assert (legal_op)
				else $error("instruction_decoder: unknown opcode %h", instruction.r.opcode);
		end
	end

endmodule

//--- verilog/instruction_memory.sv
// ############################
// no reset, fill through the load port
// while the core sits in reset
// ############################
module instruction_memory
#(
	parameter int PC_W = 8 // byte address width
)
(
	input  logic                clk,
	input  logic                load_en,
	input  logic [PC_W-3:0]     load_addr, // word index
	input  mips_pkg::word_t     load_data,
	input  logic [PC_W-1:0]     pc,
	output mips_pkg::word_t     instruction
);
	import mips_pkg::*;

	localparam int DEPTH = 2 ** (PC_W - 2); // words

	word_t          mem [DEPTH]; // program store
	logic [PC_W-3:0] word_idx; // pc >> 2

	always_ff @(posedge clk)
	begin
		if (load_en)
		begin
			mem[load_addr] <= load_data; // loader only, core never writes
		end
	end

	assign word_idx    = pc[PC_W-1:2]; // drop byte offset
	assign instruction = mem[word_idx]; // async read, same cycle as pc

	// fetch only ever steps in whole words
	a_pc_aligned : assert property (@(posedge clk) pc[1:0] == 2'b00)
		else $error("instruction_memory: misaligned pc %h", pc);

endmodule

//--- verilog/mips_core.sv
// ############################
// single cycle, one retire per clk
// load the program while reset is high
// ############################
module mips_core
#(
	parameter int PC_W    = 8, // imem holds 2^(PC_W-2) words
	parameter int DMEM_AW = 6
)
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 load_en,
	input  logic [PC_W-3:0]      load_addr, // word index
	input  mips_pkg::word_t      load_data,
	output logic                 retire_valid,
	output logic [PC_W-1:0]      retire_pc,
	output logic                 retire_wb_en,
	output mips_pkg::reg_idx_t   retire_wb_reg,
	output mips_pkg::word_t      retire_wb_data,
	output logic                 store_en,
	output mips_pkg::word_t      store_addr, // word bits only
	output mips_pkg::word_t      store_data
);
	import mips_pkg::*;

	logic [PC_W-1:0] pc;
	instr_u          instruction;
	alu_op_e         alu_op;
	logic            alu_src_imm;
	logic            use_shamt;
	logic            mem_read;
	logic            mem_write;
	logic            is_branch;
	logic            zero;
	logic            branch_taken;
	logic            running; // core out of reset this cycle
	logic [4:0]      shamt;
	logic [4:0]      alu_shamt;
	word_t           imm;
	word_t           alu_b;
	word_t           alu_result;
	word_t           wb_data;

	regfile_if rf_bus ();
	dmem_if    dm_bus ();

	fetch_unit #(.PC_W (PC_W)) i_fetch_unit
	(
		.clk           (clk),
		.reset         (reset),
		.load_en       (load_en),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.branch_taken  (branch_taken),
		.branch_offset (imm),
		.pc            (pc),
		.instruction   (instruction)
	);

	instruction_decoder i_instruction_decoder
	(
		.instruction (instruction),
		.rf          (rf_bus.core),
		.alu_op      (alu_op),
		.alu_src_imm (alu_src_imm),
		.use_shamt   (use_shamt),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.is_branch   (is_branch),
		.imm         (imm),
		.shamt       (shamt)
	);

	register_file i_register_file (.clk (clk), .reset (reset), .rf (rf_bus.regs));

	assign alu_b     = alu_src_imm ? imm : rf_bus.rd2;
	assign alu_shamt = use_shamt ? shamt : 5'd0; // only shifts see shamt

	alu i_alu
	(
		.a      (rf_bus.rd1),
		.b      (alu_b),
		.shamt  (alu_shamt),
		.op     (alu_op),
		.result (alu_result),
		.zero   (zero)
	);

	assign running      = ~reset; // pc 0 executes in the first cycle after reset
	assign branch_taken = is_branch & zero; // beq rs == rt
	assign dm_bus.addr  = alu_result; // rs + imm
	assign dm_bus.wdata = rf_bus.rd2;
	assign dm_bus.we    = mem_write & running; // stored program may start with sw

	data_memory #(.DMEM_AW (DMEM_AW)) i_data_memory (.clk (clk), .reset (reset), .dm (dm_bus.mem));

	assign wb_data   = mem_read ? dm_bus.rdata : alu_result; // lw or alu
	assign rf_bus.wd = wb_data;

	// trace of the instruction executing now
	assign retire_valid   = running;
	assign retire_pc      = pc;
	assign retire_wb_en   = running & rf_bus.we & (rf_bus.wa != '0); // r0 writes hidden
	assign retire_wb_reg  = rf_bus.wa;
	assign retire_wb_data = wb_data;
	assign store_en       = dm_bus.we;
	assign store_addr     = word_t'({alu_result[DMEM_AW+1:2], 2'b00}); // as the memory decodes it
	assign store_data     = dm_bus.wdata;

endmodule

//--- verilog/mips_pkg.sv
// ############################
// encodings follow standard MIPS32
// only the subset run by mips_core
// ############################
package mips_pkg;

	typedef logic [31:0] word_t; // data word
	typedef logic [4:0]  reg_idx_t; // register index

	typedef enum logic [5:0]
	{
		OP_RTYPE = 6'h00, // alu ops, decoded by funct
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0]
	{
		FN_SLL = 6'h00, // all-zero word lands here as nop
		FN_SRL = 6'h02,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	typedef enum logic [2:0]
	{
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1, // also the beq compare
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4, // signed
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6
	} alu_op_e;

	typedef struct packed
	{
		opcode_e  opcode; // [31:26]
		reg_idx_t rs; // [25:21]
		reg_idx_t rt; // [20:16]
		reg_idx_t rd; // [15:11]
		logic [4:0] shamt; // [10:6]
		funct_e   funct; // [5:0]
	} r_fields_t;

	typedef struct packed
	{
		opcode_e  opcode;
		reg_idx_t rs; // base or first operand
		reg_idx_t rt; // dest for addi/lw, data for sw
		logic [15:0] imm; // sign extended in decode
	} i_fields_t;

	// one fetched word, two views
	typedef union packed
	{
		r_fields_t r;
		i_fields_t i;
	} instr_u;

endpackage

//--- verilog/register_file.sv
// ############################
// r0 reads zero, writes to it dropped
// ############################
module register_file
(
	input  logic      clk,
	input  logic      reset,
	regfile_if.regs   rf
);
	import mips_pkg::*;

	word_t regs [32]; // architectural registers

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int k = 0; k < 32; k++)
			begin
				regs[k] <= '0; // all clear, r0 included
			end
		end
		else if (rf.we && (rf.wa != '0))
		begin
			regs[rf.wa] <= rf.wd; // lands at end of the retiring cycle
		end
	end

	// no bypass, a read in the writing cycle returns the old value
	assign rf.rd1 = regs[rf.ra1];
	assign rf.rd2 = regs[rf.ra2];

	// r0 must stay zero whatever the decoder asks for
	a_r0_port1 : assert property (@(posedge clk) disable iff (reset)
		(rf.ra1 == '0) |-> (rf.rd1 == '0))
		else $error("register_file: r0 read nonzero on port 1");

	a_r0_port2 : assert property (@(posedge clk) disable iff (reset)
		(rf.ra2 == '0) |-> (rf.rd2 == '0))
		else $error("register_file: r0 read nonzero on port 2");

endmodule
